/* source/dp_pkg.sv */
// shared widths, types and constants for the dual-port mailbox
// the port count is fixed at two, so a port index fits in one bit
// the synchronizer supports depths of two to five stages only

package dp_pkg;

   // number of peer ports that share the mailbox memory
   localparam int dp_channels = 2;

   // address and data widths of the shared register file
   localparam int dp_addr_w = 4;
   localparam int dp_data_w = 16;

   // the memory holds one word for every address
   localparam int dp_words = 1 << dp_addr_w;

   // deepest synchronizer chain that sync_ctrl can select
   localparam int dp_sync_max_depth = 5;

   // a word address into the mailbox memory
   typedef logic [dp_addr_w-1:0] dp_addr_t;

   // one mailbox memory word
   typedef logic [dp_data_w-1:0] dp_data_t;

   // index of a port, wide enough for dp_channels ports
   typedef logic [0:0] dp_chan_t;

   // selects a synchronizer depth of 2 plus its value
   typedef logic [1:0] dp_sync_ctrl_t;

   // bundled access of one port, held stable while its request is low
   typedef struct packed {
      logic     write;
      dp_addr_t addr;
      dp_data_t wdata;
   } dp_access_t;

   // states of the handshake responder
   typedef enum logic [1:0] {
      wait_req_assert,
      wait_ack_assert,
      wait_req_deassert
   } dp_resp_state_t;

endpackage

/* source/dp_sync.sv */
// multi-stage synchronizer for one active-low level
// the chain resets to 1 so an idle request reads as deasserted
// sync_ctrl should only change while the input is quiet

module dp_sync (
   input  logic                  si_clk,
   input  logic                  async_reset_n,
   input  logic                  sync_reset_n,
   input  dp_pkg::dp_sync_ctrl_t sync_ctrl,
   input  logic                  d,
   output logic                  o
);

   // shift chain, stage 0 samples the asynchronous input
   logic [dp_pkg::dp_sync_max_depth-1:0] chain;

   // index of the stage that feeds the output
   logic [2:0] tap;

   // every clock moves the input one stage further down the chain
   always_ff @(posedge si_clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         chain <= '1;
      end else begin
         if (!sync_reset_n) begin
            // the synchronous reset clears the chain just like the async one
            chain <= '1;
         end else begin
            chain <= {chain[dp_pkg::dp_sync_max_depth-2:0], d};
         end
      end
   end

   // depth 2 taps stage 1, depth 5 taps stage 4
   assign tap = {1'b0, sync_ctrl} + 3'd1;

   // the tap moves with sync_ctrl, so the latency is 2 plus its value
   assign o = chain[tap];

endmodule

/* source/dp_hs_resp.sv */
// four-phase handshake responder for one requester port
// ai_req_n may arrive from any clock domain and is synchronized here
// the requester must keep ai_req_n low until ai_ack_n falls

module dp_hs_resp (
   input  logic                  async_reset_n,
   input  logic                  sync_reset_n,
   input  dp_pkg::dp_sync_ctrl_t sync_ctrl,
   input  logic                  si_clk,
   output logic                  si_req_n,
   input  logic                  si_ack_n,
   input  logic                  ai_req_n,
   output logic                  ai_ack_n
);

   // request after the synchronizer, safe to use in the si_clk domain
   logic sync_ai_req_n;

   // current and next responder state
   dp_pkg::dp_resp_state_t state;
   dp_pkg::dp_resp_state_t next_state;

   // next values of the registered outputs
   logic next_si_req_n;
   logic next_ai_ack_n;

   // bring the outside request into the si_clk domain
   dp_sync req_sync (
      .si_clk        (si_clk),
      .async_reset_n (async_reset_n),
      .sync_reset_n  (sync_reset_n),
      .sync_ctrl     (sync_ctrl),
      .d             (ai_req_n),
      .o             (sync_ai_req_n)
   );

   // state and outputs are all registered, both resets return to idle
   always_ff @(posedge si_clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         state    <= dp_pkg::wait_req_assert;
         si_req_n <= 1'b1;
         ai_ack_n <= 1'b1;
      end else begin
         if (!sync_reset_n) begin
            state    <= dp_pkg::wait_req_assert;
            si_req_n <= 1'b1;
            ai_ack_n <= 1'b1;
         end else begin
            state    <= next_state;
            si_req_n <= next_si_req_n;
            ai_ack_n <= next_ai_ack_n;
         end
      end
   end

   // next state decoder
   always_comb begin
      next_state    = state;
      next_si_req_n = 1'b1;
      next_ai_ack_n = 1'b1;
      case (state)
         dp_pkg::wait_req_assert: begin
            // a synchronized low request raises the internal request
            if (!sync_ai_req_n) begin
               next_state    = dp_pkg::wait_ack_assert;
               next_si_req_n = 1'b0;
            end
         end
         dp_pkg::wait_ack_assert: begin
            // hold the internal request until the arbiter acknowledges it
            if (!si_ack_n) begin
               next_state    = dp_pkg::wait_req_deassert;
               next_ai_ack_n = 1'b0;
            end else begin
               next_si_req_n = 1'b0;
            end
         end
         dp_pkg::wait_req_deassert: begin
            // the outward acknowledge stays low while the requester holds its request
            if (sync_ai_req_n) begin
               next_state = dp_pkg::wait_req_assert;
            end else begin
               next_ai_ack_n = 1'b0;
            end
         end
         default: begin
            // unused encoding, fall back to idle
            next_state = dp_pkg::wait_req_assert;
         end
      endcase
   end

endmodule

/* source/dp_channel.sv */
// one requester port of the mailbox
// ai_rdata holds the last read word and is valid once ai_ack_n is low
// for a write the register holds the word that was overwritten

module dp_channel (
   input  logic                  si_clk,
   input  logic                  async_reset_n,
   input  logic                  sync_reset_n,
   input  dp_pkg::dp_sync_ctrl_t sync_ctrl,
   input  logic                  ai_req_n,
   output logic                  ai_ack_n,
   output dp_pkg::dp_data_t      ai_rdata,
   output logic                  si_req_n,
   input  logic                  si_ack_n,
   input  logic                  rdata_load,
   input  dp_pkg::dp_data_t      mem_rdata
);

   // read data register presented to the requester
   dp_pkg::dp_data_t rdata_q;

   // the responder turns the outside handshake into an si_clk request
   dp_hs_resp resp (
      .async_reset_n (async_reset_n),
      .sync_reset_n  (sync_reset_n),
      .sync_ctrl     (sync_ctrl),
      .si_clk        (si_clk),
      .si_req_n      (si_req_n),
      .si_ack_n      (si_ack_n),
      .ai_req_n      (ai_req_n),
      .ai_ack_n      (ai_ack_n)
   );

   // rdata_load arrives with si_ack_n, so the word is captured on the
   // same edge that lowers ai_ack_n
   always_ff @(posedge si_clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         rdata_q <= '0;
      end else begin
         if (!sync_reset_n) begin
            rdata_q <= '0;
         end else if (rdata_load) begin
            rdata_q <= mem_rdata;
         end
      end
   end

   // the register only changes on a new access, so it stays stable
   // through the rest of the requester's handshake
   assign ai_rdata = rdata_q;

endmodule

/* source/dp_arbiter.sv */
// round-robin arbiter for the shared mailbox memory
// ai_access is read without synchronizing, it is stable while a request is pending
// one access per cycle, the winner gets a one-cycle si_ack_n pulse

module dp_arbiter (
   input  logic                                             si_clk,
   input  logic                                             async_reset_n,
   input  logic                                             sync_reset_n,
   input  logic [dp_pkg::dp_channels-1:0]                   si_req_n,
   input  dp_pkg::dp_access_t [dp_pkg::dp_channels-1:0]     ai_access,
   output logic [dp_pkg::dp_channels-1:0]                   si_ack_n,
   output logic [dp_pkg::dp_channels-1:0]                   rdata_load,
   output logic                                             mem_en,
   output dp_pkg::dp_access_t                               mem_access
);

   // ports with a request that is not being acknowledged right now
   logic [dp_pkg::dp_channels-1:0] pending;

   // round-robin pointer, the port it names has first priority
   dp_pkg::dp_chan_t ptr;

   // winner of this cycle and a candidate used while searching
   dp_pkg::dp_chan_t grant;
   dp_pkg::dp_chan_t cand;
   logic             grant_valid;

   // a port whose acknowledge is low still shows its request, so skip it
   assign pending = ~si_req_n & si_ack_n;

   // search from the lowest priority up, so the highest pending one wins
   always_comb begin
      grant_valid = 1'b0;
      grant       = ptr;
      cand        = ptr;
      for (int i = dp_pkg::dp_channels - 1; i >= 0; i--) begin
         cand = dp_pkg::dp_chan_t'((int'(ptr) + i) % dp_pkg::dp_channels);
         if (pending[cand]) begin
            grant_valid = 1'b1;
            grant       = cand;
         end
      end
   end

   // the memory performs the granted access on this same edge
   assign mem_en     = grant_valid;
   assign mem_access = ai_access[grant];

   // acknowledge and load pulses, and the pointer update
   always_ff @(posedge si_clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         si_ack_n   <= '1;
         rdata_load <= '0;
         ptr        <= '0;
      end else begin
         if (!sync_reset_n) begin
            si_ack_n   <= '1;
            rdata_load <= '0;
            ptr        <= '0;
         end else begin
            for (int p = 0; p < dp_pkg::dp_channels; p++) begin
               si_ack_n[p]   <= !(grant_valid && grant == dp_pkg::dp_chan_t'(p));
               rdata_load[p] <= grant_valid && grant == dp_pkg::dp_chan_t'(p);
            end
            // the pointer moves just past the port that was served
            if (grant_valid) begin
               ptr <= dp_pkg::dp_chan_t'((int'(grant) + 1) % dp_pkg::dp_channels);
            end
         end
      end
   end

endmodule

/* source/dp_mailbox_mem.sv */
// register-file memory of the mailbox, one access per cycle
// both resets clear every word, so it is built from flip-flops
// a write returns the word that was stored before it

module dp_mailbox_mem (
   input  logic               si_clk,
   input  logic               async_reset_n,
   input  logic               sync_reset_n,
   input  logic               mem_en,
   input  dp_pkg::dp_access_t mem_access,
   output dp_pkg::dp_data_t   mem_rdata
);

   // the storage array
   dp_pkg::dp_data_t mem [dp_pkg::dp_words];

   // the read register changes only on an enabled access, so it holds
   // its value through the acknowledge cycle that follows
   always_ff @(posedge si_clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         for (int w = 0; w < dp_pkg::dp_words; w++) begin
            mem[w] <= '0;
         end
         mem_rdata <= '0;
      end else begin
         if (!sync_reset_n) begin
            for (int w = 0; w < dp_pkg::dp_words; w++) begin
               mem[w] <= '0;
            end
            mem_rdata <= '0;
         end else if (mem_en) begin
            // read the old word, then overwrite it on a write
            mem_rdata <= mem[mem_access.addr];
            if (mem_access.write) begin
               mem[mem_access.addr] <= mem_access.wdata;
            end
         end
      end
   end

endmodule

/* source/dp_mailbox_top.sv */
// dual-port mailbox, two outside requesters share one register file
// each port uses a four-phase active-low handshake with bundled data
// only one access per port may be outstanding at a time

module dp_mailbox_top (
   input  logic                                         si_clk,
   input  logic                                         async_reset_n,
   input  logic                                         sync_reset_n,
   input  dp_pkg::dp_sync_ctrl_t                        sync_ctrl,
   input  logic [dp_pkg::dp_channels-1:0]               ai_req_n,
   input  dp_pkg::dp_access_t [dp_pkg::dp_channels-1:0] ai_access,
   output logic [dp_pkg::dp_channels-1:0]               ai_ack_n,
   output dp_pkg::dp_data_t [dp_pkg::dp_channels-1:0]   ai_rdata
);

   // per-port requests and acknowledges in the si_clk domain
   logic [dp_pkg::dp_channels-1:0] si_req_n;
   logic [dp_pkg::dp_channels-1:0] si_ack_n;
   logic [dp_pkg::dp_channels-1:0] rdata_load;

   // the single memory access granted this cycle
   logic               mem_en;
   dp_pkg::dp_access_t mem_access;
   dp_pkg::dp_data_t   mem_rdata;

   // one channel per requester port
   for (genvar p = 0; p < dp_pkg::dp_channels; p++) begin : g_chan
      dp_channel chan (
         .si_clk        (si_clk),
         .async_reset_n (async_reset_n),
         .sync_reset_n  (sync_reset_n),
         .sync_ctrl     (sync_ctrl),
         .ai_req_n      (ai_req_n[p]),
         .ai_ack_n      (ai_ack_n[p]),
         .ai_rdata      (ai_rdata[p]),
         .si_req_n      (si_req_n[p]),
         .si_ack_n      (si_ack_n[p]),
         .rdata_load    (rdata_load[p]),
         .mem_rdata     (mem_rdata)
      );
   end

   // the arbiter picks one pending port each cycle
   dp_arbiter arb (
      .si_clk        (si_clk),
      .async_reset_n (async_reset_n),
      .sync_reset_n  (sync_reset_n),
      .si_req_n      (si_req_n),
      .ai_access     (ai_access),
      .si_ack_n      (si_ack_n),
      .rdata_load    (rdata_load),
      .mem_en        (mem_en),
      .mem_access    (mem_access)
   );

   // shared storage, read data goes to every channel
   dp_mailbox_mem mem (
      .si_clk        (si_clk),
      .async_reset_n (async_reset_n),
      .sync_reset_n  (sync_reset_n),
      .mem_en        (mem_en),
      .mem_access    (mem_access),
      .mem_rdata     (mem_rdata)
   );

endmodule

/* test/dp_mailbox_checker.sv */
// compares the read data of every completed access on both ports with a model
// the ports must not write one word while both are busy, the model order is unknown then

module dp_mailbox_checker (
   input  logic                                         si_clk,
   input  logic                                         async_reset_n,
   input  logic                                         sync_reset_n,
   input  dp_pkg::dp_access_t [dp_pkg::dp_channels-1:0] ai_access,
   input  logic [dp_pkg::dp_channels-1:0]               ai_ack_n,
   input  dp_pkg::dp_data_t [dp_pkg::dp_channels-1:0]   ai_rdata,
   output int                                           checks,
   output int                                           errors
);

   // contents the mailbox should hold
   dp_pkg::dp_data_t model [dp_pkg::dp_words];

   // reset seen at the last rising edge, acknowledges seen at the last falling edge
   logic                           in_reset   = 1'b1;
   logic [dp_pkg::dp_channels-1:0] prev_ack_n = '1;

   // expected read data, the last word written to the address
   function automatic dp_pkg::dp_data_t expected_word(input dp_pkg::dp_addr_t addr);
      return model[addr];
   endfunction

   initial begin
      checks = 0;
      errors = 0;
   end

   // inputs change on the falling edge, so the rising edge sees them settled
   always @(posedge si_clk) begin
      in_reset <= !async_reset_n || !sync_reset_n;
   end

   // outputs change on the rising edge and are compared half a cycle later
   always @(negedge si_clk) begin
      if (in_reset) begin
         // either reset clears the memory, the acknowledges and the read data
         for (int w = 0; w < dp_pkg::dp_words; w++) begin
            model[w] = '0;
         end
         if (ai_ack_n !== '1 || ai_rdata !== '0) begin
            errors++;
            $display("Mismatch at time %0t: ack %b rdata %h in reset, expected idle and zero",
                     $time, ai_ack_n, ai_rdata);
         end
      end else begin
         for (int p = 0; p < dp_pkg::dp_channels; p++) begin
            // a falling acknowledge marks the end of a transfer
            if (prev_ack_n[p] && !ai_ack_n[p]) begin
               checks++;
               // a read and a write both return the word stored before the access
               if (ai_rdata[p] !== expected_word(ai_access[p].addr)) begin
                  errors++;
                  $display("Mismatch at time %0t: port %0d word %0d returned %h, expected %h",
                           $time, p, ai_access[p].addr, ai_rdata[p],
                           expected_word(ai_access[p].addr));
               end
               if (ai_access[p].write) begin
                  model[ai_access[p].addr] = ai_access[p].wdata;
               end
            end
         end
      end
      prev_ack_n = ai_ack_n;
   end

endmodule

/* test/dp_mailbox_asserts.sv */
// concurrent checks on the handshake responder, bound to every instance
// each instance keeps a count of its own failed checks

module dp_mailbox_asserts (
   input logic                   si_clk,
   input logic                   async_reset_n,
   input logic                   sync_reset_n,
   input logic                   si_req_n,
   input logic                   ai_ack_n,
   input logic                   sync_ai_req_n,
   input dp_pkg::dp_resp_state_t state
);

   // number of failed assertions in this instance
   int failures = 0;

   // the internal request and the outward acknowledge are never low together
   req_ack_exclusive: assert property (@(posedge si_clk) disable iff (!async_reset_n)
      si_req_n || ai_ack_n)
      else begin
         $error("si_req_n and ai_ack_n are low at the same time");
         failures++;
      end

   // the acknowledge holds until the synchronized request goes high
   ack_held: assert property (@(posedge si_clk) disable iff (!async_reset_n || !sync_reset_n)
      (state == dp_pkg::wait_req_deassert && !sync_ai_req_n) |=> !ai_ack_n)
      else begin
         $error("ai_ack_n rose while the synchronized request was still low");
         failures++;
      end

   // either reset leaves both outputs high on the next edge
   reset_idle: assert property (@(posedge si_clk)
      (!async_reset_n || !sync_reset_n) |=> (si_req_n && ai_ack_n))
      else begin
         $error("responder outputs not high after reset");
         failures++;
      end

endmodule

bind dp_hs_resp dp_mailbox_asserts resp_asserts (.*);

/* test/dp_mailbox_tb.sv */
// testbench of the dual-port mailbox, requester inputs change on the falling edge
// port 0 owns words 0 to 7 and port 1 words 8 to 15 while both are busy

module dp_mailbox_tb;

   // transfers of tests 1 to 6, which size the timeout
   localparam int transfers      = 16 + 32 + 48 + 16 + 64 + 20;
   localparam int timeout_cycles = transfers * 30 + 200;
   localparam int half           = dp_pkg::dp_words / 2;

   logic                                         si_clk;
   logic                                         async_reset_n;
   logic                                         sync_reset_n;
   dp_pkg::dp_sync_ctrl_t                        sync_ctrl;
   logic [dp_pkg::dp_channels-1:0]               ai_req_n;
   dp_pkg::dp_access_t [dp_pkg::dp_channels-1:0] ai_access;
   logic [dp_pkg::dp_channels-1:0]               ai_ack_n;
   dp_pkg::dp_data_t [dp_pkg::dp_channels-1:0]   ai_rdata;

   int          checks;
   int          errors;
   int          assert_fails;
   int          cycles = 0;
   logic [31:0] rng_state = 32'hacfb;

   dp_mailbox_top uut (.*);

   dp_mailbox_checker chk (.*);

   always #50 si_clk = ~si_clk;

   // the run ends here if a handshake never completes
   always @(posedge si_clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // one four-phase transfer on port p, returns once ai_ack_n is high again
   task automatic transfer(input int p, input logic write, input int addr,
                           input dp_pkg::dp_data_t wdata);
      dp_pkg::dp_access_t acc;
      acc.write = write;
      acc.addr  = dp_pkg::dp_addr_t'(addr);
      acc.wdata = wdata;
      @(negedge si_clk);
      ai_access[p] = acc;
      ai_req_n[p]  = 1'b0;
      do @(negedge si_clk); while (ai_ack_n[p]);
      ai_req_n[p] = 1'b1;
      do @(negedge si_clk); while (!ai_ack_n[p]);
   endtask

   // random reads and writes inside the port's own half
   task automatic random_ops(input int p, input int count);
      logic [31:0] r;
      for (int i = 0; i < count; i++) begin
         r = next_random();
         transfer(p, r[0], p * half + int'(r[3:1]), r[31:16]);
      end
   endtask

   task automatic read_words(input int p, input int first, input int count);
      for (int i = 0; i < count; i++) begin
         transfer(p, 1'b0, first + i, '0);
      end
   endtask

   // random data into consecutive words, then all of them read back
   task automatic write_read(input int p, input int first, input int count);
      for (int i = 0; i < count; i++) begin
         transfer(p, 1'b1, first + i, dp_pkg::dp_data_t'(next_random() >> 8));
      end
      read_words(p, first, count);
   endtask

   task automatic finish_test(input int num, input string name);
      repeat (4) @(negedge si_clk);
      $display("test %0d %s done: %0d transfers, %0d errors so far", num, name, checks, errors);
   endtask

   initial begin
      si_clk        = 1'b0;
      async_reset_n = 1'b0;
      sync_reset_n  = 1'b1;
      sync_ctrl     = '0;
      ai_req_n      = '1;
      ai_access     = '0;
      repeat (5) @(negedge si_clk);
      async_reset_n = 1'b1;
      repeat (2) @(negedge si_clk);
      read_words(0, 0, dp_pkg::dp_words);
      finish_test(1, "reset contents");
      write_read(0, 0, dp_pkg::dp_words);
      finish_test(2, "single port");
      fork
         random_ops(0, 24);
         random_ops(1, 24);
      join
      finish_test(3, "concurrent traffic");
      // each port now sees the last words written by the other one
      fork
         read_words(0, half, half);
         read_words(1, 0, half);
      join
      finish_test(4, "cross reads");
      // the depth only changes while both requests are idle
      for (int v = 0; v < 4; v++) begin
         sync_ctrl = dp_pkg::dp_sync_ctrl_t'(v);
         repeat (6) @(negedge si_clk);
         fork
            write_read(0, 0, 4);
            write_read(1, half, 4);
         join
      end
      finish_test(5, "sync depths");
      sync_reset_n = 1'b0;
      repeat (2) @(negedge si_clk);
      sync_reset_n = 1'b1;
      repeat (2) @(negedge si_clk);
      read_words(0, 0, dp_pkg::dp_words);
      write_read(1, half, 2);
      finish_test(6, "sync reset");
      assert_fails = uut.g_chan[0].chan.resp.resp_asserts.failures
                   + uut.g_chan[1].chan.resp.resp_asserts.failures;
      $display("%0d transfers, %0d errors, %0d assertion failures",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* verilog.f */
source/dp_pkg.sv
source/dp_sync.sv
source/dp_hs_resp.sv
source/dp_channel.sv
source/dp_arbiter.sv
source/dp_mailbox_mem.sv
source/dp_mailbox_top.sv
test/dp_mailbox_checker.sv
test/dp_mailbox_asserts.sv
test/dp_mailbox_tb.sv

/* Bender.yml */
package:
  name: dp_mailbox

sources:
  - source/dp_pkg.sv
  - source/dp_sync.sv
  - source/dp_hs_resp.sv
  - source/dp_channel.sv
  - source/dp_arbiter.sv
  - source/dp_mailbox_mem.sv
  - source/dp_mailbox_top.sv
  - target: test
    files:
      - test/dp_mailbox_checker.sv
      - test/dp_mailbox_asserts.sv
      - test/dp_mailbox_tb.sv
